/* flist.f */
+incdir+include
verilog/core_regs_pkg.sv
verilog/core_io_pkg.sv
verilog/core_cfg_if.sv
verilog/core_setting_reg.sv
verilog/core_setting_bank.sv
verilog/core_readback.sv
verilog/core_misc_outputs.sv
verilog/core_ctrl_top.sv
verification/tb_core_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the core control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_core_ctrl -f flist.f --Mdir obj_dir > "$LOG" 2>&1 \
  && ./obj_dir/Vtb_core_ctrl >> "$LOG" 2>&1 \
  || echo "build or run returned an error" >> "$LOG"

grep -qx "Simulation passed" "$LOG" && echo "PASS, see $LOG" && exit 0 \
  || { echo "FAIL, see $LOG"; exit 1; }

/* verification/tb_core_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// core control testbench
// directed tests of settings writes, readback, lock sync and spi sharing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_version.svh"

module tb_core_ctrl;
  import core_regs_pkg::*;
  import core_io_pkg::*;

  // clock edges allowed for a lock change to reach readback
  localparam int LOCK_TIMEOUT = 4;

  logic        bus_clk;
  logic        bus_rst;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [31:0] o_rb_data;
  logic [1:0]  i_lock_signals;
  logic [3:0]  i_tcxo_status;
  logic [1:0]  o_pps_select;
  logic        o_mimo;
  logic        o_codec_arst;
  logic        o_time_sync;
  logic [7:0]  o_xb_local_addr;
  logic        i_spi0_sen;
  logic        i_spi0_sclk;
  logic        i_spi0_mosi;
  logic        i_spi1_sen;
  logic        i_spi1_sclk;
  logic        i_spi1_mosi;
  logic        o_spi_sen;
  logic        o_spi_sclk;
  logic        o_spi_mosi;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] rng_state = 32'd10;
  // expected register contents
  core_misc_t  exp_misc;
  logic [31:0] exp_test;
  logic [7:0]  exp_xb;

  core_ctrl_top uut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #2 bus_clk = ~bus_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // field positions of the misc word
  function automatic core_misc_t misc_from_word(logic [31:0] d);
    core_misc_t m;
    m = '0;
    m.pps_select = d[1:0];
    m.mimo       = d[2];
    m.codec_arst = d[3];
    m.time_sync  = d[21];
    return m;
  endfunction

  task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_misc(core_misc_t exp, string what);
    checks++;
    if (o_pps_select !== exp.pps_select || o_mimo !== exp.mimo ||
        o_codec_arst !== exp.codec_arst || o_time_sync !== exp.time_sync) begin
      errors++;
      $display("error at %0t: %s got pps %0d mimo %b arst %b sync %b, expected %0d %b %b %b",
               $time, what, o_pps_select, o_mimo, o_codec_arst, o_time_sync,
               exp.pps_select, exp.mimo, exp.codec_arst, exp.time_sync);
    end
  endtask

  task automatic check_spi(core_spi_t exp, string what);
    core_spi_t got;
    got = '{sen: o_spi_sen, sclk: o_spi_sclk, mosi: o_spi_mosi};
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // called 1 ns after an edge and returns 1 ns after the sampling edge
  task automatic set_write(logic [7:0] addr, logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(posedge bus_clk);
    #1;
    i_set_stb = 1'b0;
  endtask

  task automatic read_rb(rb_sel_t sel, output logic [31:0] word);
    set_write(SR_CORE_READBACK, {27'd0, sel});
    word = o_rb_data;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic verify_reset();
    logic [31:0] word;
    exp_misc = misc_from_word(32'd2);
    exp_test = 32'd0;
    exp_xb   = 8'd40;
    check_misc(exp_misc, "reset misc outputs");
    check_word({24'd0, o_xb_local_addr}, {24'd0, exp_xb}, "reset xb local");
    read_rb(RB_CORE_TEST, word);
    check_word(word, exp_test, "reset test word");
  endtask

  task automatic exercise_test_reg();
    logic [31:0] word;
    logic [7:0]  unmapped [4] = '{8'd1, 8'd8, 8'd29, 8'd255};
    for (int i = 0; i < 4; i++) begin
      exp_test = next_random();
      set_write(SR_CORE_TEST, exp_test);
      read_rb(RB_CORE_TEST, word);
      check_word(word, exp_test, "test word readback");
    end
    // select stays on the test index through these writes
    foreach (unmapped[i]) begin
      set_write(unmapped[i], next_random());
      check_word(o_rb_data, exp_test, "test word after unmapped write");
      check_misc(exp_misc, "misc after unmapped write");
      check_word({24'd0, o_xb_local_addr}, {24'd0, exp_xb}, "xb local after unmapped write");
    end
  endtask

  task automatic decode_misc();
    logic [31:0] words [5];
    words[0] = 32'h0020_000f;
    words[1] = 32'h0000_0001;
    words[2] = next_random();
    words[3] = next_random();
    words[4] = 32'h0000_0002;
    foreach (words[i]) begin
      i_set_stb  = 1'b1;
      i_set_addr = SR_CORE_MISC;
      i_set_data = words[i];
      #1;
      check_misc(exp_misc, "misc before sampling edge");
      @(posedge bus_clk);
      #1;
      i_set_stb = 1'b0;
      exp_misc  = misc_from_word(words[i]);
      check_misc(exp_misc, "misc after write");
    end
    exp_xb = 8'(next_random());
    set_write(SR_CORE_XB_LOCAL, {24'hff_ffff, exp_xb});
    check_word({24'd0, o_xb_local_addr}, {24'd0, exp_xb}, "xb local after write");
  endtask

  task automatic walk_readback_map();
    logic [31:0] word;
    rb_sel_t     unlisted [5] = '{5'd0, 5'd5, 5'd23, 5'd25, 5'd31};
    read_rb(RB_CORE_COMPAT, word);
    check_word(word, `CORE_COMPAT_WORD, "compat word");
    read_rb(RB_CORE_GITHASH, word);
    check_word(word, `CORE_GIT_HASH, "git hash");
    i_tcxo_status = 4'b1011;
    read_rb(RB_CORE_MISC, word);
    check_word(word, {26'd0, 4'b1011, exp_misc.pps_select}, "misc readback");
    foreach (unlisted[i]) begin
      read_rb(unlisted[i], word);
      check_word(word, 32'hdeadbeef, "unlisted index");
    end
  endtask

  // lock must reach readback on the second edge and no earlier
  task automatic wait_lock(logic [1:0] val);
    int cycles;
    cycles = 0;
    i_lock_signals = val;
    while (o_rb_data[1:0] !== val && cycles < LOCK_TIMEOUT) begin
      @(posedge bus_clk);
      #1;
      cycles++;
    end
    if (o_rb_data[1:0] !== val) begin
      errors++;
      $display("timeout: pll lock readback never showed %b", val);
    end else begin
      check_word(32'(cycles), 32'd2, "lock latency in cycles");
      check_word(o_rb_data, {30'd0, val}, "pll readback word");
    end
  endtask

  task automatic track_pll_lock();
    logic [31:0] word;
    read_rb(RB_CORE_PLL, word);
    check_word(word, 32'd0, "pll readback idle");
    wait_lock(2'b01);
    wait_lock(2'b11);
    wait_lock(2'b10);
    wait_lock(2'b00);
  endtask

  task automatic share_spi_port();
    core_spi_t s0;
    core_spi_t s1;
    core_spi_t exp;
    for (int i = 0; i < 64; i++) begin
      s0 = core_spi_t'(i[5:3]);
      s1 = core_spi_t'(i[2:0]);
      @(posedge bus_clk);
      #1;
      {i_spi0_sen, i_spi0_sclk, i_spi0_mosi} = s0;
      {i_spi1_sen, i_spi1_sclk, i_spi1_mosi} = s1;
      #1;
      exp.sen  = s0.sen & s1.sen;
      exp.sclk = s0.sen ? s1.sclk : s0.sclk;
      exp.mosi = s0.sen ? s1.mosi : s0.mosi;
      check_spi(exp, "shared spi port");
    end
  endtask

  initial begin
    bus_rst        = 1'b1;
    i_set_stb      = 1'b0;
    i_set_addr     = 8'd0;
    i_set_data     = 32'd0;
    i_lock_signals = 2'b00;
    i_tcxo_status  = 4'd0;
    i_spi0_sen     = 1'b1;
    i_spi0_sclk    = 1'b0;
    i_spi0_mosi    = 1'b0;
    i_spi1_sen     = 1'b1;
    i_spi1_sclk    = 1'b0;
    i_spi1_mosi    = 1'b0;
    repeat (3) @(posedge bus_clk);
    #1;
    bus_rst = 1'b0;

    verify_reset();
    exercise_test_reg();
    decode_misc();
    walk_readback_map();
    track_pll_lock();
    share_spi_port();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_core_ctrl

/* verilog/core_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// core control top
// settings registers, readback and misc outputs on the bus clock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_ctrl_top (
  input  logic        bus_clk,
  input  logic        bus_rst,
  // settings bus
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  output logic [31:0] o_rb_data,
  // status in
  input  logic [1:0]  i_lock_signals,
  input  logic [3:0]  i_tcxo_status,
  // board controls
  output logic [1:0]  o_pps_select,
  output logic        o_mimo,
  output logic        o_codec_arst,
  output logic        o_time_sync,
  output logic [7:0]  o_xb_local_addr,
  // channel spi masters
  input  logic        i_spi0_sen,
  input  logic        i_spi0_sclk,
  input  logic        i_spi0_mosi,
  input  logic        i_spi1_sen,
  input  logic        i_spi1_sclk,
  input  logic        i_spi1_mosi,
  // shared spi port
  output logic        o_spi_sen,
  output logic        o_spi_sclk,
  output logic        o_spi_mosi
);
  import core_io_pkg::*;

  core_spi_t spi0;
  core_spi_t spi1;
  core_spi_t spi_out;

  core_cfg_if cfg ();

  core_setting_bank u_bank (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .cfg        (cfg.bank)
  );

  core_readback u_readback (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .cfg            (cfg.readback),
    .i_lock_signals (i_lock_signals),
    .i_tcxo_status  (i_tcxo_status),
    .o_rb_data      (o_rb_data)
  );

  // spi pins to structs and back
  assign spi0 = '{sen: i_spi0_sen, sclk: i_spi0_sclk, mosi: i_spi0_mosi};
  assign spi1 = '{sen: i_spi1_sen, sclk: i_spi1_sclk, mosi: i_spi1_mosi};

  core_misc_outputs u_outputs (
    .cfg             (cfg.outputs),
    .i_spi0          (spi0),
    .i_spi1          (spi1),
    .o_spi           (spi_out),
    .o_pps_select    (o_pps_select),
    .o_mimo          (o_mimo),
    .o_codec_arst    (o_codec_arst),
    .o_time_sync     (o_time_sync),
    .o_xb_local_addr (o_xb_local_addr)
  );

  assign o_spi_sen  = spi_out.sen;
  assign o_spi_sclk = spi_out.sclk;
  assign o_spi_mosi = spi_out.mosi;

endmodule : core_ctrl_top

/* verilog/core_misc_outputs.sv */
////////////////////////////////////////////////////////////////////////////
// core misc outputs
// misc field decode and spi port sharing between two masters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_misc_outputs (
  core_cfg_if.outputs            cfg,
  input  core_io_pkg::core_spi_t i_spi0,
  input  core_io_pkg::core_spi_t i_spi1,
  output core_io_pkg::core_spi_t o_spi,
  output logic [1:0]             o_pps_select,
  output logic                   o_mimo,
  output logic                   o_codec_arst,
  output logic                   o_time_sync,
  output logic [7:0]             o_xb_local_addr
);

  // misc fields straight out to the board
  assign o_pps_select    = cfg.misc.pps_select;
  assign o_mimo          = cfg.misc.mimo;
  assign o_codec_arst    = cfg.misc.codec_arst;
  // time sync leaves as a bus clock level
  assign o_time_sync     = cfg.misc.time_sync;
  assign o_xb_local_addr = cfg.xb_local;

  ////////////////////////////////////////////////////////////////////////////
  // spi sharing
  ////////////////////////////////////////////////////////////////////////////

  // chip select low if either master selects
  assign o_spi.sen = i_spi0.sen & i_spi1.sen;

  // channel 0 wins while its enable is low
  always_comb begin
    if (!i_spi0.sen) begin
      o_spi.sclk = i_spi0.sclk;
      o_spi.mosi = i_spi0.mosi;
    end else begin
      o_spi.sclk = i_spi1.sclk;
      o_spi.mosi = i_spi1.mosi;
    end
  end

endmodule : core_misc_outputs

/* verilog/core_readback.sv */
////////////////////////////////////////////////////////////////////////////
// core readback
// pll lock synchronizer and readback word mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_version.svh"

module core_readback (
  input  logic         bus_clk,
  input  logic         bus_rst,
  core_cfg_if.readback cfg,
  input  logic [1:0]   i_lock_signals,
  input  logic [3:0]   i_tcxo_status,
  output logic [31:0]  o_rb_data
);
  import core_regs_pkg::*;

  logic [1:0] lock_meta;
  logic [1:0] lock_sync;

  ////////////////////////////////////////////////////////////////////////////
  // lock synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // lock inputs come from the rf chip asynchronous to bus_clk
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cfg.rb_sel)
      RB_CORE_TEST:    o_rb_data = cfg.test;
      RB_CORE_MISC:    o_rb_data = {26'd0, i_tcxo_status, cfg.misc.pps_select};
      RB_CORE_COMPAT:  o_rb_data = `CORE_COMPAT_WORD;
      RB_CORE_GITHASH: o_rb_data = `CORE_GIT_HASH;
      RB_CORE_PLL:     o_rb_data = {30'd0, lock_sync};
      default:         o_rb_data = RB_DEFAULT_WORD;
    endcase
  end

endmodule : core_readback

/* verilog/core_setting_bank.sv */
////////////////////////////////////////////////////////////////////////////
// core settings bank
// decodes settings bus writes into the four core registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_setting_bank (
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  core_cfg_if.bank    cfg
);
  import core_regs_pkg::*;
  import core_io_pkg::*;

  // readback select
  core_setting_reg #(
    .ADDR      (SR_CORE_READBACK),
    .T         (rb_sel_t),
    .RESET_VAL (RB_SEL_RESET)
  ) u_sr_readback (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_stb   (i_set_stb),
    .i_addr  (i_set_addr),
    .i_data  (i_set_data),
    .o_value (cfg.rb_sel)
  );

  // scratch word for bus checks
  core_setting_reg #(
    .ADDR      (SR_CORE_TEST),
    .T         (logic [31:0]),
    .RESET_VAL (TEST_RESET)
  ) u_sr_test (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_stb   (i_set_stb),
    .i_addr  (i_set_addr),
    .i_data  (i_set_data),
    .o_value (cfg.test)
  );

  // misc control comes up on internal pps
  core_setting_reg #(
    .ADDR      (SR_CORE_MISC),
    .T         (core_misc_t),
    .RESET_VAL (MISC_RESET)
  ) u_sr_misc (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_stb   (i_set_stb),
    .i_addr  (i_set_addr),
    .i_data  (i_set_data),
    .o_value (cfg.misc)
  );

  core_setting_reg #(
    .ADDR      (SR_CORE_XB_LOCAL),
    .T         (logic [7:0]),
    .RESET_VAL (XB_LOCAL_RESET)
  ) u_sr_xb_local (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_stb   (i_set_stb),
    .i_addr  (i_set_addr),
    .i_data  (i_set_data),
    .o_value (cfg.xb_local)
  );

endmodule : core_setting_bank

/* verilog/core_setting_reg.sv */
////////////////////////////////////////////////////////////////////////////
// settings register
// loads one payload from the settings bus on an address match
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_setting_reg #(
  parameter logic [7:0] ADDR      = 8'd0,
  parameter type        T         = logic [31:0],
  parameter T           RESET_VAL = '0
) (
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic        i_stb,
  input  logic [7:0]  i_addr,
  input  logic [31:0] i_data,
  output T            o_value
);

  // upper data bits beyond the payload are dropped
  localparam int W = $bits(T);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_value <= RESET_VAL;
    end else if (i_stb && (i_addr == ADDR)) begin
      o_value <= T'(i_data[W-1:0]);
    end
  end

endmodule : core_setting_reg

/* verilog/core_cfg_if.sv */
////////////////////////////////////////////////////////////////////////////
// core configuration interface
// carries the four register values from the settings bank
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface core_cfg_if ();
  import core_regs_pkg::*;
  import core_io_pkg::*;

  rb_sel_t     rb_sel;
  logic [31:0] test;
  core_misc_t  misc;
  logic [7:0]  xb_local;

  // register owner
  modport bank (output rb_sel, output test, output misc, output xb_local);

  modport readback (input rb_sel, input test, input misc);

  modport outputs (input misc, input xb_local);

endinterface : core_cfg_if

/* verilog/core_io_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// core output types
// misc register fields and the shared spi port
////////////////////////////////////////////////////////////////////////////

package core_io_pkg;

  localparam logic [1:0] PPS_INTERNAL = 2'd2;

  // misc control word from the msb down
  typedef struct packed {
    logic [9:0]  spare_hi;
    logic        time_sync;
    logic [16:0] spare_mid;
    logic        codec_arst;
    logic        mimo;
    logic [1:0]  pps_select;
  } core_misc_t;

  // internal pps selected and everything else off
  localparam core_misc_t MISC_RESET = '{
    spare_hi:   10'd0,
    time_sync:  1'b0,
    spare_mid:  17'd0,
    codec_arst: 1'b0,
    mimo:       1'b0,
    pps_select: PPS_INTERNAL
  };

  // one spi master with an active low sen
  typedef struct packed {
    logic sen;
    logic sclk;
    logic mosi;
  } core_spi_t;

endpackage : core_io_pkg

/* verilog/core_regs_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// core register map
// settings addresses, readback indices and register reset values
////////////////////////////////////////////////////////////////////////////

package core_regs_pkg;

  // readback select as written to SR_CORE_READBACK
  typedef logic [4:0] rb_sel_t;

  ////////////////////////////////////////////////////////////////////////////
  // settings bus addresses
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] SR_CORE_READBACK = 8'd0;
  localparam logic [7:0] SR_CORE_MISC     = 8'd4;
  localparam logic [7:0] SR_CORE_TEST     = 8'd28;
  localparam logic [7:0] SR_CORE_XB_LOCAL = 8'd32;

  ////////////////////////////////////////////////////////////////////////////
  // readback indices
  ////////////////////////////////////////////////////////////////////////////

  localparam rb_sel_t RB_CORE_MISC    = 5'd1;
  localparam rb_sel_t RB_CORE_COMPAT  = 5'd2;
  localparam rb_sel_t RB_CORE_GITHASH = 5'd3;
  localparam rb_sel_t RB_CORE_PLL     = 5'd4;
  localparam rb_sel_t RB_CORE_TEST    = 5'd24;

  // returned for any index not in the map
  localparam logic [31:0] RB_DEFAULT_WORD = 32'hdeadbeef;

  // reset values
  localparam rb_sel_t     RB_SEL_RESET   = 5'd0;
  localparam logic [31:0] TEST_RESET     = 32'd0;
  // crossbar local address
  localparam logic [7:0]  XB_LOCAL_RESET = 8'd40;

endpackage : core_regs_pkg

/* include/core_version.svh */
////////////////////////////////////////////////////////////////////////////
// core version words returned on readback
////////////////////////////////////////////////////////////////////////////

`ifndef CORE_VERSION_SVH
`define CORE_VERSION_SVH

// major ac, minor ff
`define CORE_COMPAT_WORD 32'hAC00FF00
`define CORE_GIT_HASH    32'h5e1f0c3a

`endif
